// File: rtl/qla_cfg.svh
`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// Motor channel count (2 up to 16)
`define QLA_NUM_CHAN 4

// Channel index width
`define QLA_CHAN_W 4

// Signed setpoint and feedback width
`define QLA_CUR_W 16

// Timestamp width, fills a whole sample word
`define QLA_TS_W 32

// Largest feedback change per sysclk cycle
`define QLA_SLEW 64

// Idle cycles before the watchdog trips
`define QLA_WDOG_LIMIT 200

`endif

// File: rtl/qla_pkg.sv
`default_nettype none

`include "qla_cfg.svh"

package qla_pkg;

    typedef logic [`QLA_CHAN_W-1:0]       chan_t;      // Channel index
    typedef logic signed [`QLA_CUR_W-1:0] current_t;   // Motor current, two's complement
    typedef logic [`QLA_TS_W-1:0]         timestamp_t; // Free-running cycle count

    // Zero fill between enable bit and feedback in a channel word
    localparam int SAMPLE_PAD_W = 32 - `QLA_CHAN_W - 1 - `QLA_CUR_W;

    // Real-time write command from the host
    typedef struct packed {
        chan_t    chan;     // Target channel
        logic     amp_en;   // Amplifier enable
        current_t setpoint; // Commanded current
    } rt_cmd_t;

    // Per-channel status towards the sampler
    typedef struct packed {
        logic     amp_en;   // Gated by the watchdog
        current_t feedback; // Modeled measured current
    } chan_status_t;

    // One word of the sample stream
    // Header words reuse all 32 bits for the timestamp
    typedef struct packed {
        chan_t                   chan;
        logic                    amp_en;
        logic [SAMPLE_PAD_W-1:0] pad;      // Always zero
        current_t                feedback;
    } sample_word_t;

    // Block sampler FSM
    typedef enum logic [1:0] {
        S_IDLE, // Waiting for sample_start
        S_HEAD, // Timestamp word on the stream
        S_CHAN  // Channel words on the stream
    } sampler_state_t;

endpackage

`default_nettype wire

// File: rtl/rt_write_dispatch.sv
`default_nettype none

`include "qla_cfg.svh"

module rt_write_dispatch
    import qla_pkg::*;
(
    input  wire                      sysclk,
    input  wire                      rst_n,
    input  wire                      cmd_valid,
    input  wire rt_cmd_t             cmd,
    output logic                     cmd_ready,
    output logic                     cmd_err,      // Pulse on out-of-range channel
    output logic [`QLA_NUM_CHAN-1:0] wr_en,        // One-hot channel strobe
    output current_t                 wr_setpoint,
    output logic                     wr_amp_en,
    output logic                     wdog_timeout
);

    localparam int NUM_CHAN = `QLA_NUM_CHAN;
    localparam int WDOG_W   = $clog2(`QLA_WDOG_LIMIT + 1);
    localparam logic [NUM_CHAN-1:0] STROBE_BASE = 1;

    logic              accept;
    logic              chan_ok;
    logic [WDOG_W-1:0] wdog_cnt;

    assign accept  = cmd_valid & cmd_ready;
    assign chan_ok = int'(cmd.chan) < NUM_CHAN; // Compare wide so 16 channels still work

    // Single-cycle writes, so ready only drops in reset
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            cmd_ready <= 1'b0;
        else
            cmd_ready <= 1'b1;
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en   <= '0;
            cmd_err <= 1'b0;
        end else begin
            wr_en   <= (accept && chan_ok) ? (STROBE_BASE << cmd.chan) : '0;
            cmd_err <= accept && !chan_ok;                // Accepted but dropped
        end
    end

    // Shared write data, qualified by wr_en
    always_ff @(posedge sysclk) begin
        if (accept) begin
            wr_setpoint <= cmd.setpoint;
            wr_amp_en   <= cmd.amp_en;
        end
    end

    // Watchdog kept alive by any accepted command
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else if (accept) begin
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_cnt == WDOG_W'(`QLA_WDOG_LIMIT)) begin
            wdog_timeout <= 1'b1; // Counter parks at the limit
        end else begin
            wdog_cnt <= wdog_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/motor_channel.sv
`default_nettype none

`include "qla_cfg.svh"

module motor_channel
    import qla_pkg::*;
(
    input  wire           sysclk,
    input  wire           rst_n,
    input  wire           wr_en,        // Strobe for this channel only
    input  wire current_t wr_setpoint,
    input  wire           wr_amp_en,
    input  wire           wdog_timeout, // Forces the output off
    output chan_status_t  status
);

    localparam int CUR_W = `QLA_CUR_W;

    // One extra bit so the error never wraps
    localparam logic signed [CUR_W:0] SLEW_POS = `QLA_SLEW;
    localparam logic signed [CUR_W:0] SLEW_NEG = -`QLA_SLEW;

    current_t                setpoint_q;
    logic                    amp_en_q;
    current_t                feedback_q;
    logic                    drive_on;
    current_t                target;
    logic signed [CUR_W:0]   err;
    logic signed [CUR_W:0]   step;
    logic signed [CUR_W+1:0] fb_sum;

    // Command registers
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            setpoint_q <= '0;
            amp_en_q   <= 1'b0;
        end else if (wr_en) begin
            setpoint_q <= wr_setpoint;
            amp_en_q   <= wr_amp_en;
        end
    end

    assign drive_on = amp_en_q & ~wdog_timeout;
    assign target   = drive_on ? setpoint_q : '0; // Coast to zero when off

    always_comb begin
        err = target - feedback_q;          // Signed difference, 17 bits
        if (err > SLEW_POS)
            step = SLEW_POS;
        else if (err < SLEW_NEG)
            step = SLEW_NEG;
        else
            step = err;                     // Close enough, land exactly
        fb_sum = feedback_q + step;
    end

    // Modeled current sensor
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            feedback_q <= '0;
        else
            feedback_q <= fb_sum[CUR_W-1:0]; // Stays in range since target does
    end

    assign status.amp_en   = drive_on;   // Reported off during timeout
    assign status.feedback = feedback_q;

endmodule

`default_nettype wire

// File: rtl/block_sampler.sv
`default_nettype none

`include "qla_cfg.svh"

module block_sampler
    import qla_pkg::*;
(
    input  wire                                   sysclk,
    input  wire                                   rst_n,
    input  wire                                   sample_start,
    input  wire chan_status_t [`QLA_NUM_CHAN-1:0] chan_status,
    input  wire                                   sample_ready,
    output logic                                  sample_valid,
    output sample_word_t                          sample_data,
    output logic                                  sample_busy
);

    localparam int NUM_CHAN = `QLA_NUM_CHAN;

    sampler_state_t                   state;
    chan_t                            idx;       // Channel word on the stream
    timestamp_t                       ts;
    timestamp_t                       ts_snap;
    chan_status_t [NUM_CHAN-1:0]      stat_snap;
    logic                             capture;
    logic                             xfer;
    logic                             last_chan;

    assign sample_valid = (state != S_IDLE);
    assign sample_busy  = (state != S_IDLE); // Covers capture through last word
    assign capture      = sample_start && (state == S_IDLE); // Start ignored while busy
    assign xfer         = sample_valid & sample_ready;
    assign last_chan    = (int'(idx) == NUM_CHAN - 1);

    // Free-running timestamp
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            ts <= '0;
        else
            ts <= ts + 1'b1;
    end

    // Snapshot of the whole board on the start edge
    always_ff @(posedge sysclk) begin
        if (capture) begin
            ts_snap   <= ts;
            stat_snap <= chan_status;
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (capture)
                        state <= S_HEAD;
                end
                S_HEAD: begin
                    if (xfer) begin
                        state <= S_CHAN;
                        idx   <= '0;   // Channel 0 comes first
                    end
                end
                S_CHAN: begin
                    if (xfer) begin
                        if (last_chan)
                            state <= S_IDLE;
                        else
                            idx <= idx + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Word mux, held stable until transfer
    always_comb begin
        sample_data = '0;
        case (state)
            S_HEAD: sample_data = sample_word_t'(ts_snap);
            S_CHAN: begin
                sample_data.chan     = idx;
                sample_data.amp_en   = stat_snap[idx].amp_en;
                sample_data.feedback = stat_snap[idx].feedback;
            end
            default: sample_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/qla_board.sv
`default_nettype none

`include "qla_cfg.svh"

module qla_board
    import qla_pkg::*;
(
    input  wire          sysclk,
    input  wire          rst_n,

    // Real-time write stream from host
    input  wire          cmd_valid,
    output logic         cmd_ready,
    input  wire rt_cmd_t cmd,
    output logic         cmd_err,

    output logic         wdog_timeout,

    // Sample stream to host
    input  wire          sample_start,
    input  wire          sample_ready,
    output logic         sample_valid,
    output sample_word_t sample_data,
    output logic         sample_busy
);

    logic [`QLA_NUM_CHAN-1:0]         wr_en;       // Per-channel write strobes
    current_t                         wr_setpoint; // Shared by all channels
    logic                             wr_amp_en;
    chan_status_t [`QLA_NUM_CHAN-1:0] chan_status;

    rt_write_dispatch dispatch_i (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_ready    (cmd_ready),
        .cmd_err      (cmd_err),
        .wr_en        (wr_en),
        .wr_setpoint  (wr_setpoint),
        .wr_amp_en    (wr_amp_en),
        .wdog_timeout (wdog_timeout)
    );

    // Identical motor channels
    for (genvar i = 0; i < `QLA_NUM_CHAN; i++) begin : g_chan
        motor_channel chan_i (
            .sysclk       (sysclk),
            .rst_n        (rst_n),
            .wr_en        (wr_en[i]),
            .wr_setpoint  (wr_setpoint),
            .wr_amp_en    (wr_amp_en),
            .wdog_timeout (wdog_timeout),
            .status       (chan_status[i])
        );
    end

    block_sampler sampler_i (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .chan_status  (chan_status),
        .sample_ready (sample_ready),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_busy  (sample_busy)
    );

endmodule

`default_nettype wire

// File: test/qla_board_chk.sv
`default_nettype none

`include "qla_cfg.svh"

module qla_board_chk
    import qla_pkg::*;
(
    input wire               sysclk,
    input wire               rst_n,
    input wire               cmd_valid,
    input wire               cmd_ready,
    input wire rt_cmd_t      cmd,
    input wire               wdog_timeout,
    input wire               sample_start,
    input wire               sample_ready,
    input wire               sample_valid,
    input wire sample_word_t sample_data,
    input wire               sample_busy
);

    // Host side of the command stream
    cmd_hold_a: assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("command dropped or changed before acceptance");

    // Sample word held under back-pressure
    sample_hold_a: assert property (@(posedge sysclk) disable iff (!rst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample_data))
        else $error("sample word dropped or changed before transfer");

    ready_high_a: assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_ready |=> cmd_ready)
        else $error("cmd_ready fell outside reset");

    // Start during a readout is ignored
    start_busy_a: assert property (@(posedge sysclk) disable iff (!rst_n)
        sample_busy && sample_start && !(sample_valid && sample_ready)
        |=> sample_busy && $stable(sample_data))
        else $error("sample_start disturbed a running readout");

    wdog_clear_a: assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_valid && cmd_ready |=> !wdog_timeout)
        else $error("watchdog still timed out after an accepted command");

    // Timeout is sticky until the next command
    wdog_hold_a: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout && !(cmd_valid && cmd_ready) |=> wdog_timeout)
        else $error("watchdog timeout cleared without a command");

endmodule

bind qla_board qla_board_chk chk_i (.*);

`default_nettype wire

// File: test/qla_board_tb.sv
`default_nettype none

`include "qla_cfg.svh"

module qla_board_tb
    import qla_pkg::*;
();

    localparam int NUM_CHAN    = `QLA_NUM_CHAN;
    localparam int NUM_STIM    = 8;
    localparam int CMD_TIMEOUT = 20;
    localparam int RD_TIMEOUT  = 30 * (NUM_CHAN + 1); // Generous for random ready

    typedef struct packed {
        rt_cmd_t cmd;
        logic    do_sample;  // Read the board after settling
        logic    rand_ready; // Random back-pressure on the readout
        logic    exp_err;
    } stim_t;

    logic         sysclk = 1'b0;
    logic         rst_n;
    logic         cmd_valid;
    logic         cmd_ready;
    rt_cmd_t      cmd;
    logic         cmd_err;
    logic         wdog_timeout;
    logic         sample_start;
    logic         sample_ready;
    logic         sample_valid;
    sample_word_t sample_data;
    logic         sample_busy;

    stim_t        stim [NUM_STIM];
    stim_t        revive;              // Write that ends the timeout
    logic         model_en [NUM_CHAN]; // Reference copy of each channel
    current_t     model_sp [NUM_CHAN];
    integer       seed = 32'hf869;
    int           checks;
    int           errors;
    int           timeouts;
    logic         have_ts;
    timestamp_t   last_ts;
    int           settle;

    qla_board qla_board_i (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd          (cmd),
        .cmd_err      (cmd_err),
        .wdog_timeout (wdog_timeout),
        .sample_start (sample_start),
        .sample_ready (sample_ready),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_busy  (sample_busy)
    );

    always #10 sysclk = ~sysclk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic flag_timeout(input string what);
        $display("Timeout: %s", what);
        timeouts++;
    endtask

    function automatic stim_t make_entry(input int chan, input logic en, input int sp,
                                         input logic smp, input logic rr, input logic err);
        stim_t e;
        e.cmd.chan     = chan_t'(chan);
        e.cmd.amp_en   = en;
        e.cmd.setpoint = current_t'(sp);
        e.do_sample    = smp;
        e.rand_ready   = rr;
        e.exp_err      = err;
        return e;
    endfunction

    function automatic logic next_ready(input logic rand_ready);
        if (rand_ready)
            return ($random(seed) & 32'sd1) != 0; // Coin flip per cycle
        return 1'b1;
    endfunction

    // Cycles to slew from 0 to the largest setpoint in the table
    function automatic int settle_cycles();
        int big;
        int mag;
        big = 0;
        for (int i = 0; i < NUM_STIM; i++) begin
            mag = int'(stim[i].cmd.setpoint);
            mag = (mag < 0) ? -mag : mag;
            if (mag > big)
                big = mag;
        end
        return big / `QLA_SLEW + 4;
    endfunction

    task automatic load_table();
        stim[0] = make_entry(0, 1'b1, 1000, 1'b0, 1'b0, 1'b0);      // No readout yet
        stim[1] = make_entry(1, 1'b1, -2000, 1'b1, 1'b1, 1'b0);
        stim[2] = make_entry(2, 1'b0, 3000, 1'b1, 1'b0, 1'b0);      // Stored but off
        stim[3] = make_entry(3, 1'b1, 500, 1'b1, 1'b1, 1'b0);
        stim[4] = make_entry(NUM_CHAN, 1'b1, 5000, 1'b1, 1'b0, 1'b1); // Just out of range
        stim[5] = make_entry(15, 1'b0, -100, 1'b1, 1'b1, 1'b1);
        stim[6] = make_entry(2, 1'b1, -3000, 1'b1, 1'b1, 1'b0);
        stim[7] = make_entry(0, 1'b0, 1200, 1'b1, 1'b0, 1'b0);      // Ramp back to 0
    endtask

    task automatic send_cmd(input rt_cmd_t c, input logic exp_err);
        int cycles;
        cycles = 0;
        @(posedge sysclk);
        #2;
        cmd_valid = 1'b1;
        cmd       = c;
        @(negedge sysclk);
        while (!cmd_ready && timeouts == 0) begin
            @(negedge sysclk);
            cycles++;
            if (cycles > CMD_TIMEOUT)
                flag_timeout("cmd_ready stayed low");
        end
        @(posedge sysclk); // Accepting edge
        #2;
        cmd_valid = 1'b0;
        cmd       = '0;
        @(negedge sysclk);
        check_val("cmd_err", 32'(cmd_err), 32'(exp_err));
        check_val("wdog_timeout", 32'(wdog_timeout), 32'h0);
        @(negedge sysclk);
        check_val("cmd_err", 32'(cmd_err), 32'h0); // One-cycle pulse only
        if (int'(c.chan) < NUM_CHAN) begin
            model_en[c.chan] = c.amp_en;
            model_sp[c.chan] = c.setpoint;
        end
    endtask

    task automatic read_sample(input logic rand_ready, input logic drive_off);
        sample_word_t words [$];
        sample_word_t held;
        sample_word_t exp_word;
        logic         hold_pending;
        logic         exp_en;
        int           cycles;
        hold_pending = 1'b0;
        cycles       = 0;
        @(posedge sysclk);
        #2;
        check_val("sample_busy", 32'(sample_busy), 32'h0);
        sample_start = 1'b1;
        sample_ready = next_ready(rand_ready);
        while (words.size() < NUM_CHAN + 1 && timeouts == 0) begin
            @(negedge sysclk);
            if (cycles > 0)
                check_val("sample_busy", 32'(sample_busy), 32'h1); // Busy through the last word
            if (hold_pending) begin
                check_val("sample_valid", 32'(sample_valid), 32'h1);
                check_val("sample_data", sample_data, held);
            end
            hold_pending = sample_valid && !sample_ready;
            held         = sample_data;
            if (sample_valid && sample_ready)
                words.push_back(sample_data); // Transfers on the coming edge
            cycles++;
            if (cycles > RD_TIMEOUT)
                flag_timeout("sample stream did not deliver all words");
            @(posedge sysclk);
            #2;
            sample_start = (cycles < 3); // Extra start pulse while busy
            sample_ready = next_ready(rand_ready);
        end
        sample_start = 1'b0;
        sample_ready = 1'b0;
        @(negedge sysclk);
        check_val("sample_valid", 32'(sample_valid), 32'h0); // No word past the last
        check_val("sample_busy", 32'(sample_busy), 32'h0);
        if (words.size() == NUM_CHAN + 1) begin
            checks++;
            assert (!have_ts || timestamp_t'(words[0]) > last_ts) else begin
                $display("ERR sample_data header %h not above previous %h", words[0], last_ts);
                errors++;
            end
            have_ts = 1'b1;
            last_ts = timestamp_t'(words[0]);
            for (int k = 0; k < NUM_CHAN; k++) begin
                exp_en            = model_en[k] && !drive_off;
                exp_word          = '0;
                exp_word.chan     = chan_t'(k);
                exp_word.amp_en   = exp_en;
                exp_word.feedback = exp_en ? model_sp[k] : '0; // Settled on target
                check_val("sample_data", words[k + 1], exp_word);
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        sample_start = 1'b0;
        sample_ready = 1'b0;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        have_ts      = 1'b0;
        last_ts      = '0;
        for (int k = 0; k < NUM_CHAN; k++) begin
            model_en[k] = 1'b0;
            model_sp[k] = '0;
        end
        load_table();
        settle = settle_cycles();

        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        check_val("cmd_ready", 32'(cmd_ready), 32'h0);       // Still in reset
        check_val("cmd_err", 32'(cmd_err), 32'h0);
        check_val("sample_valid", 32'(sample_valid), 32'h0);
        check_val("sample_busy", 32'(sample_busy), 32'h0);
        check_val("wdog_timeout", 32'(wdog_timeout), 32'h0);
        @(posedge sysclk);
        #2;
        rst_n = 1'b1;
        @(posedge sysclk);
        #2;
        check_val("cmd_ready", 32'(cmd_ready), 32'h1);

        read_sample(1'b0, 1'b0); // All channels idle

        for (int i = 0; i < NUM_STIM && timeouts == 0; i++) begin
            send_cmd(stim[i].cmd, stim[i].exp_err);
            if (stim[i].do_sample) begin
                repeat (settle) @(posedge sysclk);
                read_sample(stim[i].rand_ready, 1'b0);
            end
        end

        // Host goes quiet
        repeat (`QLA_WDOG_LIMIT + 10) @(posedge sysclk);
        #2;
        check_val("wdog_timeout", 32'(wdog_timeout), 32'h1);
        repeat (settle) @(posedge sysclk);
        read_sample(1'b1, 1'b1);

        revive = make_entry(1, 1'b1, 100, 1'b1, 1'b0, 1'b0);
        send_cmd(revive.cmd, revive.exp_err); // Revives the board
        repeat (settle) @(posedge sysclk);
        read_sample(1'b0, 1'b0);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/qla_pkg.sv
rtl/rt_write_dispatch.sv
rtl/motor_channel.sv
rtl/block_sampler.sv
rtl/qla_board.sv
test/qla_board_chk.sv
test/qla_board_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the qla_board testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module qla_board_tb -o qla_sim

# A failing assertion stops the simulator with a non-zero status
./obj_dir/qla_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
